// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // alu selections shared by OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    // alternate form selects SUB and SRA
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

// File: hw/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_WAIT_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WAIT_LOAD,
        ST_WRITEBACK
    } stage_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // what the sequencer does with an instruction
    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_NOP
    } instr_class_e;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_raddr_a,
    input  reg_idx_t i_raddr_b,
    output word_t    o_rdata_a,
    output word_t    o_rdata_b,
    input  logic     i_we,
    input  reg_idx_t i_waddr,
    input  word_t    i_wdata
);

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != 5'd0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = (i_raddr_a == 5'd0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == 5'd0) ? '0 : regs[i_raddr_b];

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  word_t        i_rs1_val,
    input  word_t        i_rs2_val,
    input  word_t        i_imm,
    input  word_t        i_pc,
    input  instr_class_e i_class,
    input  alu_op_e      i_alu_op,
    input  logic         i_use_imm,
    input  funct3_t      i_funct3,
    output word_t        o_result,
    output logic         o_branch_taken
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       cond;

    // auipc adds its immediate to the pc
    assign op_a  = (i_class == CLS_AUIPC) ? i_pc : i_rs1_val;
    assign op_b  = i_use_imm ? i_imm : i_rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:  o_result = op_a + op_b;
            ALU_SUB:  o_result = op_a - op_b;
            ALU_SLL:  o_result = op_a << shamt;
            ALU_SLT:  o_result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: o_result = {31'd0, op_a < op_b};
            ALU_XOR:  o_result = op_a ^ op_b;
            ALU_SRL:  o_result = op_a >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   o_result = op_a | op_b;
            ALU_AND:  o_result = op_a & op_b;
            default:  o_result = op_b;
        endcase
    end

    always_comb begin
        case (i_funct3)
            F3_BEQ:  cond = (i_rs1_val == i_rs2_val);
            F3_BNE:  cond = (i_rs1_val != i_rs2_val);
            F3_BLT:  cond = $signed(i_rs1_val) < $signed(i_rs2_val);
            F3_BGE:  cond = $signed(i_rs1_val) >= $signed(i_rs2_val);
            F3_BLTU: cond = i_rs1_val < i_rs2_val;
            F3_BGEU: cond = i_rs1_val >= i_rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = (i_class == CLS_BRANCH) && cond;

endmodule

// File: hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  word_t        i_instr,
    output reg_idx_t     o_rs1,
    output reg_idx_t     o_rs2,
    output reg_idx_t     o_rd,
    output word_t        o_imm,
    output instr_class_e o_class,
    output funct3_t      o_funct3,
    output alu_op_e      o_alu_op,
    output logic         o_use_imm
);

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    f7_alt;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    alu_op_e sel_op;

    assign opcode = opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign f7_alt = (funct7 == F7_ALT);

    assign o_rd     = i_instr[11:7];
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_funct3 = funct3;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'd0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // alternate form only matters for SUB and the right shifts
    always_comb begin
        case (funct3)
            F3_ADD_SUB: sel_op = (f7_alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            F3_SLL:     sel_op = ALU_SLL;
            F3_SLT:     sel_op = ALU_SLT;
            F3_SLTU:    sel_op = ALU_SLTU;
            F3_XOR:     sel_op = ALU_XOR;
            F3_SRL_SRA: sel_op = f7_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      sel_op = ALU_OR;
            default:    sel_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_class   = CLS_NOP;
        o_alu_op  = ALU_ADD;
        o_use_imm = 1'b1;
        o_imm     = imm_i;
        case (opcode)
            OPC_LUI: begin
                o_class  = CLS_LUI;
                o_alu_op = ALU_PASS_B;
                o_imm    = imm_u;
            end
            OPC_AUIPC: begin
                o_class = CLS_AUIPC;
                o_imm   = imm_u;
            end
            OPC_JAL: begin
                o_class = CLS_JAL;
                o_imm   = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_class = CLS_JALR;
                end
            end
            OPC_BRANCH: begin
                o_imm     = imm_b;
                o_use_imm = 1'b0;
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    o_class = CLS_BRANCH;
                end
            end
            OPC_LOAD: begin
                if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    o_class = CLS_LOAD;
                end
            end
            OPC_OP_IMM: begin
                o_alu_op = sel_op;
                if (!(funct3 == F3_SLL && funct7 != F7_BASE) &&
                    !(funct3 == F3_SRL_SRA && funct7 != F7_BASE && !f7_alt)) begin
                    o_class = CLS_ALU;
                end
            end
            OPC_OP: begin
                o_alu_op  = sel_op;
                o_use_imm = 1'b0;
                if (funct7 == F7_BASE ||
                    (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA))) begin
                    o_class = CLS_ALU;
                end
            end
            // fence, system and unknown words retire as nop
            default: begin
                o_class = CLS_NOP;
            end
        endcase
    end

endmodule

// File: hw/rv_wb_master.sv
`timescale 1ns/1ps

module rv_wb_master
    import rv_core_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    // core side
    input  logic  i_req,
    input  word_t i_addr,
    output logic  o_done,
    output word_t o_rdata,

    // bus side
    output logic  o_cyc,
    output logic  o_stb,
    output word_t o_addr,
    input  logic  i_stall,
    input  logic  i_ack,
    input  word_t i_data
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_WAIT
    } wb_state_e;

    wb_state_e state;
    word_t     addr_q;
    logic      ack_seen;

    // a pipelined slave may ack in the cycle it accepts
    assign ack_seen = i_ack && ((state == WB_WAIT) || (state == WB_REQ && !i_stall));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= WB_IDLE;
            o_done <= 1'b0;
        end else begin
            o_done <= ack_seen;
            case (state)
                WB_IDLE: begin
                    if (i_req) begin
                        state <= WB_REQ;
                    end
                end
                WB_REQ: begin
                    if (ack_seen) begin
                        state <= WB_IDLE;
                    end else if (!i_stall) begin
                        state <= WB_WAIT;
                    end
                end
                default: begin
                    if (ack_seen) begin
                        state <= WB_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == WB_IDLE && i_req) begin
            addr_q <= i_addr;
        end
        if (ack_seen) begin
            o_rdata <= i_data;
        end
    end

    // strobe held until accepted, cycle held until ack
    assign o_cyc  = (state != WB_IDLE);
    assign o_stb  = (state == WB_REQ);
    assign o_addr = addr_q;

endmodule

// File: hw/rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
#(
    parameter word_t PC_RESET = 32'h2040_0000
) (
    input  logic         i_clk,
    input  logic         i_rst,

    // bus side
    output logic         o_bus_req,
    output word_t        o_bus_addr,
    input  logic         i_bus_done,
    input  word_t        i_bus_rdata,

    // decoder side
    output word_t        o_instr,
    input  instr_class_e i_class,
    input  funct3_t      i_funct3,
    input  word_t        i_imm,
    input  reg_idx_t     i_rd,

    // alu side
    input  word_t        i_alu_result,
    input  logic         i_branch_taken,
    input  word_t        i_rs1_val,

    // register file write
    output logic         o_rf_we,
    output reg_idx_t     o_rf_waddr,
    output word_t        o_rf_wdata,
    output word_t        o_pc
);

    stage_e      stage;
    word_t       pc;
    word_t       instr;
    word_t       pc_plus4;
    word_t       pc_target;
    word_t       jalr_sum;
    word_t       next_pc;
    word_t       load_val;
    logic        is_load;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + i_imm;
    assign jalr_sum  = i_rs1_val + i_imm;
    assign is_load   = (i_class == CLS_LOAD);

    always_comb begin
        case (i_class)
            CLS_JAL:    next_pc = pc_target;
            CLS_JALR:   next_pc = {jalr_sum[31:1], 1'b0};
            CLS_BRANCH: next_pc = i_branch_taken ? pc_target : pc_plus4;
            default:    next_pc = pc_plus4;
        endcase
    end

    // one request per fetch, one per load
    assign o_bus_req  = (stage == ST_FETCH) || (stage == ST_EXECUTE && is_load);
    assign o_bus_addr = (stage == ST_FETCH) ? pc : i_alu_result;

    // load address stays on the alu output until writeback
    assign ld_byte = i_bus_rdata[{i_alu_result[1:0], 3'b000} +: 8];
    assign ld_half = i_alu_result[1] ? i_bus_rdata[31:16] : i_bus_rdata[15:0];

    always_comb begin
        case (i_funct3)
            F3_LB:   load_val = {{24{ld_byte[7]}}, ld_byte};
            F3_LH:   load_val = {{16{ld_half[15]}}, ld_half};
            F3_LBU:  load_val = {24'd0, ld_byte};
            F3_LHU:  load_val = {16'd0, ld_half};
            default: load_val = i_bus_rdata;
        endcase
    end

    always_comb begin
        o_rf_we    = 1'b0;
        o_rf_wdata = i_alu_result;
        if (stage == ST_EXECUTE) begin
            case (i_class)
                CLS_ALU, CLS_LUI, CLS_AUIPC: begin
                    o_rf_we = 1'b1;
                end
                CLS_JAL, CLS_JALR: begin
                    o_rf_we    = 1'b1;
                    o_rf_wdata = pc_plus4;
                end
                default: begin
                    o_rf_we = 1'b0;
                end
            endcase
        end else if (stage == ST_WRITEBACK) begin
            o_rf_we    = 1'b1;
            o_rf_wdata = load_val;
        end
    end

    assign o_rf_waddr = i_rd;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage <= ST_FETCH;
            pc    <= PC_RESET;
        end else begin
            case (stage)
                ST_FETCH: begin
                    stage <= ST_WAIT_FETCH;
                end
                ST_WAIT_FETCH: begin
                    if (i_bus_done) begin
                        stage <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    stage <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    pc    <= next_pc;
                    stage <= is_load ? ST_WAIT_LOAD : ST_FETCH;
                end
                ST_WAIT_LOAD: begin
                    if (i_bus_done) begin
                        stage <= ST_WRITEBACK;
                    end
                end
                default: begin
                    stage <= ST_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == ST_WAIT_FETCH && i_bus_done) begin
            instr <= i_bus_rdata;
        end
    end

    assign o_instr = instr;
    assign o_pc    = pc;

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
#(
    parameter word_t PC_RESET = 32'h2040_0000
) (
    input  logic  i_clk,
    input  logic  i_rst,

    // wishbone pipelined master
    input  logic  i_stall,
    input  logic  i_ack,
    input  word_t i_data,
    output logic  o_cyc,
    output logic  o_stb,
    output word_t o_addr
);

    logic         bus_req;
    word_t        bus_addr;
    logic         bus_done;
    word_t        bus_rdata;

    word_t        instr;
    word_t        pc;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    instr_class_e iclass;
    funct3_t      funct3;
    alu_op_e      alu_op;
    logic         use_imm;

    word_t        rs1_val;
    word_t        rs2_val;
    word_t        alu_result;
    logic         branch_taken;

    logic         rf_we;
    reg_idx_t     rf_waddr;
    word_t        rf_wdata;

    rv_sequencer #(
        .PC_RESET (PC_RESET)
    ) i_rv_sequencer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .o_bus_req      (bus_req),
        .o_bus_addr     (bus_addr),
        .i_bus_done     (bus_done),
        .i_bus_rdata    (bus_rdata),
        .o_instr        (instr),
        .i_class        (iclass),
        .i_funct3       (funct3),
        .i_imm          (imm),
        .i_rd           (rd),
        .i_alu_result   (alu_result),
        .i_branch_taken (branch_taken),
        .i_rs1_val      (rs1_val),
        .o_rf_we        (rf_we),
        .o_rf_waddr     (rf_waddr),
        .o_rf_wdata     (rf_wdata),
        .o_pc           (pc)
    );

    rv_decoder i_rv_decoder (
        .i_instr   (instr),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_rd      (rd),
        .o_imm     (imm),
        .o_class   (iclass),
        .o_funct3  (funct3),
        .o_alu_op  (alu_op),
        .o_use_imm (use_imm)
    );

    rv_regfile i_rv_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_raddr_a (rs1),
        .i_raddr_b (rs2),
        .o_rdata_a (rs1_val),
        .o_rdata_b (rs2_val),
        .i_we      (rf_we),
        .i_waddr   (rf_waddr),
        .i_wdata   (rf_wdata)
    );

    rv_alu i_rv_alu (
        .i_rs1_val      (rs1_val),
        .i_rs2_val      (rs2_val),
        .i_imm          (imm),
        .i_pc           (pc),
        .i_class        (iclass),
        .i_alu_op       (alu_op),
        .i_use_imm      (use_imm),
        .i_funct3       (funct3),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    rv_wb_master i_rv_wb_master (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (bus_req),
        .i_addr  (bus_addr),
        .o_done  (bus_done),
        .o_rdata (bus_rdata),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr),
        .i_stall (i_stall),
        .i_ack   (i_ack),
        .i_data  (i_data)
    );

endmodule

// File: tb/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic [31:0] i_addr,
    output logic        o_stall,
    output logic        o_ack,
    output logic [31:0] o_data
);

    // word-addressed program and data filled by the testbench
    logic [31:0] mem [logic [29:0]];

    logic [31:0] req_addr;
    int unsigned acc_cnt;
    int unsigned served_cnt;
    int unsigned ack_delay;
    int unsigned wait_cnt;

    initial begin
        o_stall    = 1'b0;
        o_ack      = 1'b0;
        o_data     = '0;
        acc_cnt    = 0;
        served_cnt = 0;
        ack_delay  = 0;
        wait_cnt   = 0;
    end

    // unwritten words read as a pattern of the full address
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return ~{a[1:0], a[31:2]} ^ 32'h6c07_8965;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst) begin
            acc_cnt <= 0;
        end else if (i_cyc && i_stb && !o_stall && acc_cnt == served_cnt) begin
            acc_cnt   <= acc_cnt + 1;
            req_addr  <= i_addr;
            ack_delay <= $urandom_range(0, 3);
        end
    end

    // outputs change on the falling edge only
    always @(negedge i_clk) begin
        o_ack <= 1'b0;
        if (i_rst) begin
            served_cnt <= 0;
            wait_cnt   <= 0;
            o_stall    <= 1'b0;
        end else begin
            o_stall <= ($urandom_range(0, 2) == 0);
            if (acc_cnt != served_cnt) begin
                if (wait_cnt >= ack_delay) begin
                    o_ack      <= 1'b1;
                    o_data     <= read_word(req_addr);
                    served_cnt <= served_cnt + 1;
                    wait_cnt   <= 0;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

endmodule

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] PC_START  = 32'h2040_0000;
    localparam logic [31:0] DATA_ADDR = 32'h2050_0000;
    localparam logic [31:0] DATA_WORD = 32'hf1e2_83a4;
    localparam int          WAIT_MAX  = 20000;

    logic        i_clk;
    logic        i_rst;
    logic        stall;
    logic        ack;
    logic [31:0] rdata;
    logic        cyc;
    logic        stb;
    logic [31:0] addr;

    logic [31:0] exp_q [$];
    logic [31:0] acc_q [$];
    logic [31:0] rf [32];
    logic [31:0] pc;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    int          rst_cycles;
    logic        prev_rst;
    logic        prev_stb;
    logic        prev_stall;
    logic        prev_cyc;
    logic        prev_ack;
    logic [31:0] prev_addr;

    rv_core_top i_rv_core_top (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (stall),
        .i_ack   (ack),
        .i_data  (rdata),
        .o_cyc   (cyc),
        .o_stb   (stb),
        .o_addr  (addr)
    );

    wb_mem_model mem_model (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_cyc   (cyc),
        .i_stb   (stb),
        .i_addr  (addr),
        .o_stall (stall),
        .o_ack   (ack),
        .o_data  (rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // record every accepted address in acc_q
    always @(posedge i_clk) begin
        if (i_rst) begin
            rst_cycles <= rst_cycles + 1;
            if (rst_cycles >= 2) begin
                assert (!cyc && !stb) else begin
                    $display("o_cyc or o_stb high during reset");
                    errors++;
                end
            end
        end else begin
            rst_cycles <= 0;
            if (prev_rst) begin
                assert (!cyc && !stb) else begin
                    $display("o_cyc or o_stb high on reset release");
                    errors++;
                end
            end
            if (stb && !stall) begin
                acc_q.push_back(addr);
            end
            if (prev_stb && prev_stall) begin
                assert (stb) else begin
                    $display("o_stb dropped before the request was accepted");
                    errors++;
                end
                assert (addr == prev_addr) else begin
                    $display("ERROR o_addr under stall was %h now %h", prev_addr, addr);
                    errors++;
                end
            end
            if (stb && !prev_stb) begin
                assert (!prev_cyc) else begin
                    $display("new request started before the ack of the last one");
                    errors++;
                end
            end
            if (prev_cyc && !prev_ack) begin
                assert (cyc) else begin
                    $display("o_cyc dropped before the ack");
                    errors++;
                end
            end
        end
        prev_rst   <= i_rst;
        prev_stb   <= stb;
        prev_stall <= stall;
        prev_cyc   <= cyc;
        prev_ack   <= ack;
        prev_addr  <= addr;
    end

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // expected results from the RV32I rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic begin_test();
        mem_model.mem.delete();
        exp_q.delete();
        pc = PC_START;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
    endtask

    task automatic emit(input logic [31:0] w);
        mem_model.mem[pc[31:2]] = w;
        exp_q.push_back(pc);
        pc = pc + 32'd4;
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            rf[rd] = v;
        end
    endtask

    // LW x31, 0(r) shows r on the address bus
    task automatic probe(input logic [4:0] r);
        emit(enc_i(12'd0, r, 3'b010, 5'd31, 7'h03));
        exp_q.push_back(rf[r]);
    endtask

    task automatic op_r(input logic [2:0] f3, input bit alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
        set_reg(rd, alu_ref(f3, alt, rf[rs1], rf[rs2]));
        probe(rd);
    endtask

    task automatic op_i(input logic [2:0] f3, input bit alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
        emit(enc_i(alt ? {7'h20, imm[4:0]} : imm, rs1, f3, rd, 7'h13));
        set_reg(rd, alu_ref(f3, alt, rf[rs1], {{20{imm[11]}}, imm}));
        probe(rd);
    endtask

    task automatic op_u(input bit is_auipc, input logic [4:0] rd, input logic [19:0] imm);
        logic [31:0] here;
        here = pc;
        emit({imm, rd, is_auipc ? 7'h17 : 7'h37});
        set_reg(rd, is_auipc ? here + {imm, 12'd0} : {imm, 12'd0});
    endtask

    task automatic br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] here;
        here = pc;
        emit(enc_b(13'd12, rs2, rs1, f3));
        if (branch_ref(f3, rf[rs1], rf[rs2])) begin
            pc = here + 32'd12;
        end
    endtask

    task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [1:0] off);
        logic [31:0] lanes;
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        logic [31:0] v;
        lanes  = DATA_WORD >> {off, 3'b000};
        lane_b = lanes[7:0];
        lane_h = lanes[15:0];
        case (f3)
            3'd0:    v = {{24{lane_b[7]}}, lane_b};
            3'd1:    v = {{16{lane_h[15]}}, lane_h};
            3'd4:    v = {24'd0, lane_b};
            3'd5:    v = {16'd0, lane_h};
            default: v = DATA_WORD;
        endcase
        emit(enc_i({10'd0, off}, 5'd1, f3, rd, 7'h03));
        exp_q.push_back(rf[1] + {30'd0, off});
        set_reg(rd, v);
        probe(rd);
    endtask

    task automatic run_program(input string name);
        int start_err;
        int n;
        start_err = errors;
        emit(enc_j(21'd0, 5'd0));
        @(negedge i_clk);
        i_rst = 1'b1;
        repeat (16) @(negedge i_clk);
        acc_q.delete();
        i_rst = 1'b0;
        n = 0;
        while (acc_q.size() < exp_q.size() && n < WAIT_MAX) begin
            @(negedge i_clk);
            n++;
        end
        if (acc_q.size() < exp_q.size()) begin
            $display("timeout in %s: saw %0d of %0d bus requests", name, acc_q.size(),
                     exp_q.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_q.size(); i++) begin
                checks++;
                assert (acc_q[i] == exp_q[i]) else begin
                    $display("ERROR o_addr #%0d got %h expected %h", i, acc_q[i], exp_q[i]);
                    errors++;
                end
            end
        end
        tests_run++;
        if (errors == start_err) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    initial begin
        void'($urandom(32'hfb069815));
        i_rst        = 1'b1;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_cycles   = 0;

        begin_test();
        for (int i = 1; i < 6; i++) begin
            emit(enc_i(12'(i), 5'd0, 3'd0, 5'(i), 7'h13));
        end
        run_program("sequential");

        begin_test();
        op_i(3'd0, 0, 5'd1, 5'd0, 12'h123);
        op_i(3'd0, 0, 5'd2, 5'd0, 12'hffb);
        op_u(0, 5'd3, 20'h12345);
        probe(5'd3);
        op_u(1, 5'd4, 20'h00001);
        probe(5'd4);
        op_r(3'd0, 0, 5'd5, 5'd1, 5'd2);
        op_r(3'd0, 1, 5'd6, 5'd1, 5'd2);
        op_r(3'd4, 0, 5'd7, 5'd1, 5'd2);
        op_r(3'd6, 0, 5'd8, 5'd1, 5'd2);
        op_r(3'd7, 0, 5'd9, 5'd1, 5'd2);
        op_r(3'd2, 0, 5'd10, 5'd2, 5'd1);
        op_r(3'd3, 0, 5'd11, 5'd2, 5'd1);
        op_i(3'd1, 0, 5'd12, 5'd1, 12'd4);
        op_i(3'd5, 0, 5'd13, 5'd2, 12'd4);
        op_i(3'd5, 1, 5'd14, 5'd2, 12'd4);
        op_r(3'd1, 0, 5'd15, 5'd2, 5'd1);
        op_r(3'd5, 0, 5'd16, 5'd2, 5'd1);
        op_r(3'd5, 1, 5'd17, 5'd2, 5'd1);
        op_i(3'd4, 0, 5'd18, 5'd1, 12'hf0f);
        op_i(3'd6, 0, 5'd19, 5'd1, 12'h800);
        op_i(3'd7, 0, 5'd20, 5'd2, 12'hff0);
        op_i(3'd2, 0, 5'd21, 5'd2, 12'hffe);
        op_i(3'd3, 0, 5'd22, 5'd1, 12'hfff);
        op_i(3'd0, 0, 5'd0, 5'd1, 12'd5);
        op_r(3'd0, 0, 5'd0, 5'd1, 5'd1);
        run_program("alu");

        begin_test();
        op_i(3'd0, 0, 5'd1, 5'd0, 12'hffe);
        op_i(3'd0, 0, 5'd2, 5'd0, 12'd3);
        br(3'd0, 5'd1, 5'd1);
        br(3'd0, 5'd1, 5'd2);
        br(3'd1, 5'd1, 5'd2);
        br(3'd1, 5'd1, 5'd1);
        br(3'd4, 5'd1, 5'd2);
        br(3'd4, 5'd2, 5'd1);
        br(3'd5, 5'd2, 5'd1);
        br(3'd5, 5'd1, 5'd2);
        br(3'd6, 5'd2, 5'd1);
        br(3'd6, 5'd1, 5'd2);
        br(3'd7, 5'd1, 5'd2);
        br(3'd7, 5'd2, 5'd1);
        run_program("branch");

        begin_test();
        emit(enc_j(21'd16, 5'd1));
        set_reg(5'd1, pc);
        pc = pc + 32'd12;
        probe(5'd1);
        op_u(1, 5'd2, 20'd0);
        emit(enc_i(12'd21, 5'd2, 3'd0, 5'd3, 7'h67));
        set_reg(5'd3, pc);
        pc = (rf[2] + 32'd21) & ~32'd1;
        probe(5'd3);
        run_program("jump");

        begin_test();
        mem_model.mem[DATA_ADDR[31:2]] = DATA_WORD;
        op_u(0, 5'd1, DATA_ADDR[31:12]);
        for (int off = 0; off < 4; off++) begin
            load(3'd0, 5'd2, 2'(off));
            load(3'd4, 5'd3, 2'(off));
        end
        load(3'd1, 5'd4, 2'd0);
        load(3'd1, 5'd4, 2'd2);
        load(3'd5, 5'd5, 2'd0);
        load(3'd5, 5'd5, 2'd2);
        load(3'd2, 5'd6, 2'd0);
        run_program("load");

        begin_test();
        emit(32'h0ff0_000f);
        emit(32'h0000_0073);
        emit(32'h0010_0073);
        emit(32'h3000_2573);
        emit(32'hffff_ffff);
        emit(32'h0000_0000);
        probe(5'd10);
        run_program("nop");

        $display("tests %0d passed %0d failed %0d, address checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: project.f
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_wb_master.sv
hw/rv_sequencer.sv
hw/rv_core_top.sv
tb/wb_mem_model.sv
tb/tb_rv_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_rv_core
FILELIST  = project.f
PASS_MSG  = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
